//--- Bender.yml
package:
  name: reg_bridge

sources:
  # Shared packages first
  - common/bus_pkg.sv
  - common/regs_pkg.sv
  # Design sources
  - afifo/afifo.sv
  - logic/host_port.sv
  - logic/reg_file.sv
  - logic/cmd_ctrl.sv
  - logic/reg_bridge.sv
  # Testbench
  - target: test
    files:
      - tests/tb_reg_bridge.sv

//--- afifo/afifo.sv
`default_nettype none

module afifo #(
	parameter type T     = logic [7:0],
	parameter int  ASIZE = 4
) (
	// Write side
	input  wire logic i_wclk,
	input  wire logic i_reset,
	input  wire logic i_wr,
	input  wire T     i_wdata,
	output logic      o_wfull,
	// Read side
	input  wire logic i_rclk,
	input  wire logic i_rreset,
	input  wire logic i_rd,
	output T          o_rdata,
	output logic      o_rempty_n
);

	// Number of entries
	localparam int DEPTH = 1 << ASIZE;

	// Storage shared by both sides
	T mem [0:DEPTH-1];

	// Write side pointers
	logic [ASIZE:0] wbin;
	logic [ASIZE:0] wgray;
	logic [ASIZE:0] wbin_next;
	logic [ASIZE:0] wgray_next;
	logic [ASIZE-1:0] waddr;
	// Read pointer as seen by the write side
	logic [ASIZE:0] wq1_rgray;
	logic [ASIZE:0] wq2_rgray;
	logic           wfull_next;

	// Read side pointers
	logic [ASIZE:0] rbin;
	logic [ASIZE:0] rgray;
	logic [ASIZE:0] rbin_next;
	logic [ASIZE:0] rgray_next;
	logic [ASIZE-1:0] raddr;
	// Write pointer as seen by the read side
	logic [ASIZE:0] rq1_wgray;
	logic [ASIZE:0] rq2_wgray;
	logic           rempty_n_next;

	////////////////////
	// Write domain
	////////////////////

	// Two flop synchronizer for the read Gray pointer
	always_ff @(posedge i_wclk) begin
		if (i_reset) begin
			wq1_rgray <= '0;
			wq2_rgray <= '0;
		end else begin
			wq1_rgray <= rgray;
			wq2_rgray <= wq1_rgray;
		end
	end

	// Advance only on an accepted write
	assign wbin_next  = wbin + {{ASIZE{1'b0}}, (i_wr && !o_wfull)};
	assign wgray_next = (wbin_next >> 1) ^ wbin_next;
	assign waddr      = wbin[ASIZE-1:0];

	// Full when the writer is one lap ahead of the reader
	// Top two Gray bits differ in that case
	assign wfull_next = (wgray_next == {~wq2_rgray[ASIZE:ASIZE-1],
		wq2_rgray[ASIZE-2:0]});

	always_ff @(posedge i_wclk) begin
		if (i_reset) begin
			wbin    <= '0;
			wgray   <= '0;
			o_wfull <= 1'b0;
		end else begin
			wbin    <= wbin_next;
			wgray   <= wgray_next;
			o_wfull <= wfull_next;
		end
	end

	// Storage write
	always_ff @(posedge i_wclk) begin
		if (i_wr && !o_wfull)
			mem[waddr] <= i_wdata;
	end

	////////////////////
	// Read domain
	////////////////////

	// Two flop synchronizer for the write Gray pointer
	always_ff @(posedge i_rclk) begin
		if (i_rreset) begin
			rq1_wgray <= '0;
			rq2_wgray <= '0;
		end else begin
			rq1_wgray <= wgray;
			rq2_wgray <= rq1_wgray;
		end
	end

	// Pop only when an entry is present
	assign rbin_next  = rbin + {{ASIZE{1'b0}}, (i_rd && o_rempty_n)};
	assign rgray_next = (rbin_next >> 1) ^ rbin_next;
	assign raddr      = rbin[ASIZE-1:0];

	// Data remains while pointers differ
	assign rempty_n_next = (rgray_next != rq2_wgray);

	always_ff @(posedge i_rclk) begin
		if (i_rreset) begin
			rbin       <= '0;
			rgray      <= '0;
			o_rempty_n <= 1'b0;
		end else begin
			rbin       <= rbin_next;
			rgray      <= rgray_next;
			o_rempty_n <= rempty_n_next;
		end
	end

	// Head entry read without a clock
	// The consumer registers it
	assign o_rdata = mem[raddr];

endmodule

`default_nettype wire

//--- common/bus_pkg.sv
`default_nettype none

package bus_pkg;

	////////////////////
	// Field widths
	////////////////////

	// Register address width
	parameter int ADDR_W = 4;

	// Register data width
	parameter int DATA_W = 16;

	////////////////////
	// Records
	////////////////////

	// Host command toward the register domain
	// Data is only meaningful for writes
	typedef struct packed {
		logic              is_write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} cmd_t;

	// Response back toward the host
	// Data is zero for writes and for errors
	typedef struct packed {
		logic              is_write;
		logic              err;
		logic [DATA_W-1:0] data;
	} rsp_t;

endpackage

`default_nettype wire

//--- common/regs_pkg.sv
`default_nettype none

package regs_pkg;

	////////////////////
	// Register map
	////////////////////

	// Read only identity
	parameter logic [bus_pkg::ADDR_W-1:0] ADDR_ID = 4'd0;

	// Free scratch register
	parameter logic [bus_pkg::ADDR_W-1:0] ADDR_SCRATCH = 4'd1;

	// Control register with masked writes
	parameter logic [bus_pkg::ADDR_W-1:0] ADDR_CTRL = 4'd2;

	// Read only count of good writes
	parameter logic [bus_pkg::ADDR_W-1:0] ADDR_WCOUNT = 4'd3;

	////////////////////
	// Register contents
	////////////////////

	// Value returned by the identity register
	parameter logic [bus_pkg::DATA_W-1:0] ID_VALUE = 16'h5a01;

	// Only the low byte of control is implemented
	parameter logic [bus_pkg::DATA_W-1:0] CTRL_MASK = 16'h00ff;

endpackage

`default_nettype wire

//--- logic/cmd_ctrl.sv
`default_nettype none

module cmd_ctrl (
	input  wire logic                       i_rclk,
	input  wire logic                       i_rreset,
	// Command FIFO read side
	input  wire logic                       i_cmd_ready_n,
	input  wire bus_pkg::cmd_t              i_cmd,
	output logic                            o_cmd_rd,
	// Response FIFO write side
	input  wire logic                       i_rsp_full,
	output logic                            o_rsp_wr,
	output bus_pkg::rsp_t                   o_rsp,
	// Register file access
	output logic                            o_reg_we,
	output logic [bus_pkg::ADDR_W-1:0]      o_reg_addr,
	output logic [bus_pkg::DATA_W-1:0]      o_reg_wdata,
	input  wire logic [bus_pkg::DATA_W-1:0] i_reg_rdata,
	input  wire logic                       i_reg_err
);

	// Idle waits for a command, push sends its response
	typedef enum logic {
		IDLE = 1'b0,
		PUSH = 1'b1
	} state_t;

	state_t state;
	logic   pop;

	////////////////////
	// Pop and access
	////////////////////

	// One command in flight at a time
	// A full response FIFO holds off the pop
	assign pop      = (state == IDLE) && i_cmd_ready_n && !i_rsp_full;
	assign o_cmd_rd = pop;

	// Register access runs off the FIFO head
	assign o_reg_we    = pop && i_cmd.is_write;
	assign o_reg_addr  = i_cmd.addr;
	assign o_reg_wdata = i_cmd.data;

	// Sequencer
	always_ff @(posedge i_rclk) begin
		if (i_rreset)
			state <= IDLE;
		else if (state == PUSH)
			state <= IDLE;
		else if (pop)
			state <= PUSH;
	end

	////////////////////
	// Response
	////////////////////

	// Built during the pop cycle
	// Writes and errors return zero data
	always_ff @(posedge i_rclk) begin
		if (pop) begin
			o_rsp.is_write <= i_cmd.is_write;
			o_rsp.err      <= i_reg_err;
			o_rsp.data     <= (i_cmd.is_write || i_reg_err) ? '0 : i_reg_rdata;
		end
	end

	// Push in the cycle after the pop
	assign o_rsp_wr = (state == PUSH);

endmodule

`default_nettype wire

//--- logic/host_port.sv
`default_nettype none

module host_port (
	input  wire logic          i_wclk,
	input  wire logic          i_reset,
	// Host command strobe
	input  wire logic          i_cmd_valid,
	input  wire bus_pkg::cmd_t i_cmd,
	output logic               o_cmd_drop,
	// Command FIFO write side
	output logic               o_fifo_wr,
	output bus_pkg::cmd_t      o_fifo_wdata,
	input  wire logic          i_fifo_full,
	// Response FIFO read side
	input  wire logic          i_rsp_ready_n,
	input  wire bus_pkg::rsp_t i_rsp,
	output logic               o_rsp_rd,
	// Host response
	output logic               o_rsp_valid,
	output bus_pkg::rsp_t      o_rsp
);

	////////////////////
	// Command path
	////////////////////

	// Strobe goes straight to the FIFO
	// The FIFO itself ignores it when full
	assign o_fifo_wr    = i_cmd_valid;
	assign o_fifo_wdata = i_cmd;

	// Report a command the FIFO refused
	always_ff @(posedge i_wclk) begin
		if (i_reset)
			o_cmd_drop <= 1'b0;
		else
			o_cmd_drop <= i_cmd_valid && i_fifo_full;
	end

	////////////////////
	// Response path
	////////////////////

	// Host is always ready so pop whenever something waits
	assign o_rsp_rd = i_rsp_ready_n;

	// One cycle valid after each pop
	always_ff @(posedge i_wclk) begin
		if (i_reset)
			o_rsp_valid <= 1'b0;
		else
			o_rsp_valid <= i_rsp_ready_n;
	end

	// Capture the FIFO head on the popping edge
	always_ff @(posedge i_wclk) begin
		if (i_rsp_ready_n)
			o_rsp <= i_rsp;
	end

endmodule

`default_nettype wire

//--- logic/reg_bridge.sv
`default_nettype none

module reg_bridge #(
	parameter int ASIZE = 4
) (
	// Host clock domain
	input  wire logic          i_wclk,
	input  wire logic          i_reset,
	// Register clock domain
	input  wire logic          i_rclk,
	input  wire logic          i_rreset,
	// Host interface
	input  wire logic          i_cmd_valid,
	input  wire bus_pkg::cmd_t i_cmd,
	output logic               o_cmd_full,
	output logic               o_cmd_drop,
	output logic               o_rsp_valid,
	output bus_pkg::rsp_t      o_rsp
);

	// Command FIFO
	logic          cmd_wr;
	bus_pkg::cmd_t cmd_wdata;
	logic          cmd_full;
	logic          cmd_rd;
	bus_pkg::cmd_t cmd_rdata;
	logic          cmd_ready_n;

	// Response FIFO
	logic          rsp_wr;
	bus_pkg::rsp_t rsp_wdata;
	logic          rsp_full;
	logic          rsp_rd;
	bus_pkg::rsp_t rsp_rdata;
	logic          rsp_ready_n;

	// Register access
	logic                       reg_we;
	logic [bus_pkg::ADDR_W-1:0] reg_addr;
	logic [bus_pkg::DATA_W-1:0] reg_wdata;
	logic [bus_pkg::DATA_W-1:0] reg_rdata;
	logic                       reg_err;

	// Let the host see back-pressure
	assign o_cmd_full = cmd_full;

	////////////////////
	// Host side
	////////////////////

	host_port u_host_port (
		.i_wclk(i_wclk), .i_reset(i_reset),
		.i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd), .o_cmd_drop(o_cmd_drop),
		.o_fifo_wr(cmd_wr), .o_fifo_wdata(cmd_wdata), .i_fifo_full(cmd_full),
		.i_rsp_ready_n(rsp_ready_n), .i_rsp(rsp_rdata), .o_rsp_rd(rsp_rd),
		.o_rsp_valid(o_rsp_valid), .o_rsp(o_rsp)
	);

	////////////////////
	// Crossings
	////////////////////

	// Host to register domain
	afifo #(.T(bus_pkg::cmd_t), .ASIZE(ASIZE)) u_cmd_fifo (
		.i_wclk(i_wclk), .i_reset(i_reset), .i_wr(cmd_wr), .i_wdata(cmd_wdata),
		.o_wfull(cmd_full),
		.i_rclk(i_rclk), .i_rreset(i_rreset), .i_rd(cmd_rd), .o_rdata(cmd_rdata),
		.o_rempty_n(cmd_ready_n)
	);

	// Register domain back to host
	afifo #(.T(bus_pkg::rsp_t), .ASIZE(ASIZE)) u_rsp_fifo (
		.i_wclk(i_rclk), .i_reset(i_rreset), .i_wr(rsp_wr), .i_wdata(rsp_wdata),
		.o_wfull(rsp_full),
		.i_rclk(i_wclk), .i_rreset(i_reset), .i_rd(rsp_rd), .o_rdata(rsp_rdata),
		.o_rempty_n(rsp_ready_n)
	);

	////////////////////
	// Register side
	////////////////////

	cmd_ctrl u_cmd_ctrl (
		.i_rclk(i_rclk), .i_rreset(i_rreset),
		.i_cmd_ready_n(cmd_ready_n), .i_cmd(cmd_rdata), .o_cmd_rd(cmd_rd),
		.i_rsp_full(rsp_full), .o_rsp_wr(rsp_wr), .o_rsp(rsp_wdata),
		.o_reg_we(reg_we), .o_reg_addr(reg_addr), .o_reg_wdata(reg_wdata),
		.i_reg_rdata(reg_rdata), .i_reg_err(reg_err)
	);

	reg_file u_reg_file (
		.i_rclk(i_rclk), .i_rreset(i_rreset),
		.i_we(reg_we), .i_addr(reg_addr), .i_wdata(reg_wdata),
		.o_rdata(reg_rdata), .o_err(reg_err)
	);

endmodule

`default_nettype wire

//--- logic/reg_file.sv
`default_nettype none

module reg_file (
	input  wire logic                       i_rclk,
	input  wire logic                       i_rreset,
	input  wire logic                       i_we,
	input  wire logic [bus_pkg::ADDR_W-1:0] i_addr,
	input  wire logic [bus_pkg::DATA_W-1:0] i_wdata,
	output logic [bus_pkg::DATA_W-1:0]      o_rdata,
	output logic                            o_err
);

	logic [bus_pkg::DATA_W-1:0] scratch;
	logic [bus_pkg::DATA_W-1:0] ctrl;
	logic [bus_pkg::DATA_W-1:0] wcount;
	logic                       wr_ok;

	////////////////////
	// Decode
	////////////////////

	// Unmapped addresses fail for reads and writes
	// Read only registers fail on writes
	assign o_err = (i_addr > regs_pkg::ADDR_WCOUNT) ||
		(i_we && (i_addr == regs_pkg::ADDR_ID || i_addr == regs_pkg::ADDR_WCOUNT));

	// Errored writes leave everything alone
	assign wr_ok = i_we && !o_err;

	always_comb begin
		case (i_addr)
			regs_pkg::ADDR_ID:      o_rdata = regs_pkg::ID_VALUE;
			regs_pkg::ADDR_SCRATCH: o_rdata = scratch;
			regs_pkg::ADDR_CTRL:    o_rdata = ctrl;
			regs_pkg::ADDR_WCOUNT:  o_rdata = wcount;
			default:                o_rdata = '0;
		endcase
	end

	////////////////////
	// Registers
	////////////////////

	always_ff @(posedge i_rclk) begin
		if (i_rreset) begin
			scratch <= '0;
			ctrl    <= '0;
			wcount  <= '0;
		end else if (wr_ok) begin
			if (i_addr == regs_pkg::ADDR_SCRATCH)
				scratch <= i_wdata;
			// Unimplemented control bits stay zero
			if (i_addr == regs_pkg::ADDR_CTRL)
				ctrl <= i_wdata & regs_pkg::CTRL_MASK;
			// Wraps naturally at the full width
			wcount <= wcount + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- tests/tb_reg_bridge.sv
`default_nettype none

module tb_reg_bridge;

	// Register domain half period
	localparam int RCLK_HALF = 35;
	// Run limit in host cycles
	// About ten times the length of all tests
	localparam int TIMEOUT_CYCLES = 4000;
	// Allowed wait per expected response
	localparam int RSP_WAIT_CYCLES = 200;
	localparam int BURST_LEN = 40;

	logic          i_wclk;
	logic          i_reset;
	logic          i_rclk;
	logic          i_rreset;
	logic          i_cmd_valid;
	bus_pkg::cmd_t i_cmd;
	logic          o_cmd_full;
	logic          o_cmd_drop;
	logic          o_rsp_valid;
	bus_pkg::rsp_t o_rsp;

	// Reference register state
	logic [15:0] m_scratch;
	logic [15:0] m_ctrl;
	logic [15:0] m_wcount;

	// Observed and expected responses in issue order
	bus_pkg::rsp_t rsp_q[$];
	bus_pkg::rsp_t exp_q[$];
	int            drop_count;
	int            error_count;
	int            checked_count;
	int            cycle_count;
	integer        seed;

	reg_bridge #(.ASIZE(4)) u_reg_bridge (
		.i_wclk(i_wclk), .i_reset(i_reset), .i_rclk(i_rclk), .i_rreset(i_rreset),
		.i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd), .o_cmd_full(o_cmd_full),
		.o_cmd_drop(o_cmd_drop), .o_rsp_valid(o_rsp_valid), .o_rsp(o_rsp)
	);

	////////////////////
	// Clocks and monitors
	////////////////////

	always #50 i_wclk = ~i_wclk;
	always #(RCLK_HALF) i_rclk = ~i_rclk;

	// Sample registered outputs away from the active edge
	always @(negedge i_wclk) begin
		if (o_rsp_valid)
			rsp_q.push_back(o_rsp);
		if (o_cmd_drop)
			drop_count++;
	end

	// Hard stop in case the bridge hangs
	always @(posedge i_wclk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Run stopped by timeout after %0d host cycles", cycle_count);
			$display("test failed");
			$finish;
		end
	end

	// Register domain reset held for two of its own cycles
	initial begin
		repeat (2) @(posedge i_rclk);
		@(negedge i_rclk);
		i_rreset = 1'b0;
	end

	////////////////////
	// Model and helpers
	////////////////////

	function automatic bus_pkg::cmd_t make_cmd(input logic w, input logic [3:0] a,
		input logic [15:0] d);
		bus_pkg::cmd_t c;
		c.is_write = w;
		c.addr     = a;
		c.data     = d;
		return c;
	endfunction

	// Expected response from the register map rules
	// Also updates the model
	function automatic bus_pkg::rsp_t model_access(input bus_pkg::cmd_t c);
		bus_pkg::rsp_t r;
		logic          bad;
		logic [15:0]   rd;
		bad = (c.addr > 4'd3) || (c.is_write &&
			(c.addr == regs_pkg::ADDR_ID || c.addr == regs_pkg::ADDR_WCOUNT));
		case (c.addr)
			regs_pkg::ADDR_ID:      rd = regs_pkg::ID_VALUE;
			regs_pkg::ADDR_SCRATCH: rd = m_scratch;
			regs_pkg::ADDR_CTRL:    rd = m_ctrl;
			default:                rd = m_wcount;
		endcase
		if (c.is_write && !bad) begin
			if (c.addr == regs_pkg::ADDR_SCRATCH)
				m_scratch = c.data;
			if (c.addr == regs_pkg::ADDR_CTRL)
				m_ctrl = c.data & regs_pkg::CTRL_MASK;
			m_wcount = m_wcount + 16'd1;
		end
		r.is_write = c.is_write;
		r.err      = bad;
		r.data     = (c.is_write || bad) ? 16'h0000 : rd;
		return r;
	endfunction

	// One cycle strobe driven on the falling edge
	task automatic send_cmd(input bus_pkg::cmd_t cmd);
		@(negedge i_wclk);
		i_cmd_valid = 1'b1;
		i_cmd       = cmd;
		exp_q.push_back(model_access(cmd));
		@(negedge i_wclk);
		i_cmd_valid = 1'b0;
	endtask

	// Wait for every outstanding response and compare in order
	task automatic collect_and_check(input string name);
		int            waited;
		int            n;
		bus_pkg::rsp_t exp;
		bus_pkg::rsp_t got;
		waited = 0;
		n      = exp_q.size();
		while (rsp_q.size() < n && waited < n * RSP_WAIT_CYCLES) begin
			@(posedge i_wclk);
			waited++;
		end
		if (drop_count != 0) begin
			$display("Commands were dropped during %s", name);
			error_count++;
		end
		while (exp_q.size() > 0) begin
			exp = exp_q.pop_front();
			if (rsp_q.size() == 0) begin
				$display("A response is missing in %s", name);
				error_count++;
			end else begin
				got = rsp_q.pop_front();
				checked_count++;
				if (got.is_write !== exp.is_write) begin
					$display("FAILED o_rsp.is_write in %s: expected %h, got %h",
						name, exp.is_write, got.is_write);
					error_count++;
				end
				if (got.err !== exp.err) begin
					$display("FAILED o_rsp.err in %s: expected %h, got %h",
						name, exp.err, got.err);
					error_count++;
				end
				if (got.data !== exp.data) begin
					$display("FAILED o_rsp.data in %s: expected %h, got %h",
						name, exp.data, got.data);
					error_count++;
				end
			end
		end
		if (rsp_q.size() != 0) begin
			$display("Unexpected extra responses arrived in %s", name);
			error_count++;
			rsp_q.delete();
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic test_reset_state();
		if (o_cmd_drop !== 1'b0 || o_rsp_valid !== 1'b0 || o_cmd_full !== 1'b0) begin
			$display("FAILED o_cmd_drop/o_rsp_valid/o_cmd_full: expected 0 0 0, got %h %h %h",
				o_cmd_drop, o_rsp_valid, o_cmd_full);
			error_count++;
		end
		for (int a = 0; a < 4; a++)
			send_cmd(make_cmd(1'b0, a[3:0], 16'h0000));
		collect_and_check("reset reads");
	endtask

	task automatic test_write_read();
		logic [31:0] r;
		r = $random(seed);
		send_cmd(make_cmd(1'b1, regs_pkg::ADDR_SCRATCH, r[15:0]));
		send_cmd(make_cmd(1'b0, regs_pkg::ADDR_SCRATCH, 16'h0000));
		// Masked register keeps its upper byte at zero
		send_cmd(make_cmd(1'b1, regs_pkg::ADDR_CTRL, r[31:16]));
		send_cmd(make_cmd(1'b0, regs_pkg::ADDR_CTRL, 16'h0000));
		send_cmd(make_cmd(1'b0, regs_pkg::ADDR_WCOUNT, 16'h0000));
		collect_and_check("write and read back");
	endtask

	task automatic test_error_access();
		logic [31:0] r;
		r = $random(seed);
		send_cmd(make_cmd(1'b1, regs_pkg::ADDR_ID, r[15:0]));
		send_cmd(make_cmd(1'b1, regs_pkg::ADDR_WCOUNT, r[31:16]));
		// Every unmapped address is read and then written
		for (int a = 4; a < 16; a++) begin
			r = $random(seed);
			send_cmd(make_cmd(1'b0, a[3:0], 16'h0000));
			send_cmd(make_cmd(1'b1, a[3:0], r[15:0]));
		end
		collect_and_check("error accesses");
		for (int a = 0; a < 4; a++)
			send_cmd(make_cmd(1'b0, a[3:0], 16'h0000));
		collect_and_check("state after errors");
	endtask

	task automatic test_random_mix();
		logic [31:0] r;
		for (int i = 0; i < 12; i++) begin
			r = $random(seed);
			// Addresses 0 to 7 mix mapped and unmapped accesses
			send_cmd(make_cmd(r[0], {1'b0, r[6:4]}, r[31:16]));
			repeat (1 + r[9:8]) @(negedge i_wclk);
		end
		collect_and_check("random mix");
	endtask

	task automatic test_id_burst();
		int            total;
		int            waited;
		bus_pkg::rsp_t got;
		waited     = 0;
		drop_count = 0;
		@(negedge i_wclk);
		i_cmd       = make_cmd(1'b0, regs_pkg::ADDR_ID, 16'h0000);
		i_cmd_valid = 1'b1;
		repeat (BURST_LEN) @(negedge i_wclk);
		i_cmd_valid = 1'b0;
		total = rsp_q.size() + drop_count;
		while (total < BURST_LEN && waited < BURST_LEN * RSP_WAIT_CYCLES) begin
			@(posedge i_wclk);
			waited++;
			total = rsp_q.size() + drop_count;
		end
		// Quiet period to catch any extra response
		repeat (RSP_WAIT_CYCLES) @(posedge i_wclk);
		total = rsp_q.size() + drop_count;
		if (total != BURST_LEN) begin
			$display("FAILED o_rsp_valid+o_cmd_drop count: expected %h, got %h",
				BURST_LEN, total);
			error_count++;
		end
		while (rsp_q.size() > 0) begin
			got = rsp_q.pop_front();
			checked_count++;
			if (got.data !== regs_pkg::ID_VALUE || got.err !== 1'b0) begin
				$display("FAILED o_rsp in burst: expected data %h err 0, got data %h err %h",
					regs_pkg::ID_VALUE, got.data, got.err);
				error_count++;
			end
			if (got.is_write !== 1'b0) begin
				$display("FAILED o_rsp.is_write in burst: expected 0, got %h",
					got.is_write);
				error_count++;
			end
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		seed          = 32'h6b6b;
		i_wclk        = 1'b0;
		i_rclk        = 1'b0;
		i_reset       = 1'b1;
		i_rreset      = 1'b1;
		i_cmd_valid   = 1'b0;
		i_cmd         = '0;
		m_scratch     = 16'h0000;
		m_ctrl        = 16'h0000;
		m_wcount      = 16'h0000;
		drop_count    = 0;
		error_count   = 0;
		checked_count = 0;
		cycle_count   = 0;
		repeat (2) @(posedge i_wclk);
		@(negedge i_wclk);
		i_reset = 1'b0;
		wait (i_rreset == 1'b0);
		@(negedge i_wclk);
		test_reset_state();
		test_write_read();
		test_error_access();
		test_random_mix();
		test_id_burst();
		$display("Checked %0d responses with %0d errors", checked_count, error_count);
		if (error_count == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
common/bus_pkg.sv
common/regs_pkg.sv
afifo/afifo.sv
logic/host_port.sv
logic/reg_file.sv
logic/cmd_ctrl.sv
logic/reg_bridge.sv
tests/tb_reg_bridge.sv
